// ==== sim/ex_golden.mem ====
// kind_op_opa_opb_opc_we_err_expfwd_expbr, one operation per line, all hex
// kind 0 alu, 1 mult, 2 csr (opa is the CSR data), 3 lsu (opa is the load data)
// op is the ALU or multiplier opcode, opc is the jump target
// we and err drive regfile_we_i and lsu_err_i, expbr is the branch decision
0_0_00000005_00000003_00001000_1_0_00000008_0
0_0_ffffffff_00000001_00001004_1_1_00000000_0
0_1_00000010_00000020_00001008_1_0_fffffff0_0
0_1_80000000_00000001_0000100c_0_0_7fffffff_0
0_2_f0f01234_0ff0ffff_00001010_1_0_00f01234_0
0_3_a5a50000_00005a5a_00001014_1_0_a5a55a5a_0
0_4_ffff0000_12345678_00001018_1_0_edcb5678_0
0_5_00000001_0000001f_0000101c_1_0_80000000_0
0_5_12345678_00000024_00001020_0_0_23456780_0
0_6_80000000_00000004_00001024_1_0_08000000_0
0_7_80000000_00000004_00001028_1_0_f8000000_0
0_7_7ffffff0_00000004_0000102c_1_1_07ffffff_0
0_8_ffffffff_00000001_00001030_1_0_00000001_1
0_9_ffffffff_00000001_00001034_1_0_00000000_0
0_8_00000005_fffffffb_00001038_1_0_00000000_0
0_a_12345678_12345678_00002000_0_0_00000000_1
0_b_12345678_12345679_00002040_0_0_00000000_1
0_c_80000000_00000000_00002080_0_0_00000000_1
0_d_00000000_80000000_000020c0_0_0_00000000_1
0_e_80000000_00000000_00002100_0_0_00000000_0
0_f_00000003_00000003_00002140_0_0_00000000_1
0_a_00000001_00000002_00002180_0_0_00000000_0
1_0_00001234_00000010_00000000_1_0_00012340_0
1_0_ffffffff_ffffffff_00000000_1_0_00000001_0
1_1_ffffffff_ffffffff_00000000_1_0_00000000_0
1_1_80000000_00000002_00000000_1_0_ffffffff_0
1_2_ffffffff_ffffffff_00000000_1_1_ffffffff_0
1_3_ffffffff_ffffffff_00000000_1_0_fffffffe_0
1_3_00010000_00010000_00000000_1_0_00000001_0
2_0_deadbeef_00000000_00000000_1_0_deadbeef_0
2_0_00000300_00000000_00000000_0_0_00000300_0
3_0_cafef00d_00000000_00000000_1_0_00000000_0

// ==== compile.f ====
+incdir+src
src/ex_pkg.sv
src/ex_alu.sv
src/ex_mult.sv
src/ex_wb_reg.sv
src/ex_stage.sv
sim/ex_stage_checker.sv
sim/ex_stage_tb.sv

// ==== Makefile ====
VERILATOR  ?= verilator
TOP        := ex_stage_tb
FILELIST   := compile.f
OBJ_DIR    := obj_dir
LINT_FLAGS := --lint-only --timing --assert
SIM_FLAGS  := --binary --timing --assert -j 0

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

# The run passes only if the pass line shows up in the output
sim:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	@out=$$(./$(OBJ_DIR)/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q "^TEST PASS$$"

clean:
	rm -rf $(OBJ_DIR)

// ==== sim/ex_stage_tb.sv ====
// Execute stage testbench
`timescale 1ns/1ns
`default_nettype none

`include "ex_cfg.svh"

module ex_stage_tb import ex_pkg::*; ();

  localparam int NUM_VEC    = 32;
  localparam int RST_CYCLES = 4;
  // 20 cycles per vector leave room for stalls and idle cycles
  localparam int MAX_CYCLES = NUM_VEC * 20 + RST_CYCLES;
  localparam int VEC_W      = 148;

  // Operation kinds in the golden file
  localparam logic [3:0] KIND_ALU  = 4'h0;
  localparam logic [3:0] KIND_MULT = 4'h1;
  localparam logic [3:0] KIND_CSR  = 4'h2;
  localparam logic [3:0] KIND_LSU  = 4'h3;

  logic                      clk = 1'b0;
  logic                      rst_n;
  logic                      alu_en_i;
  alu_op_e                   alu_operator_i;
  logic [`EX_XLEN-1:0]       alu_operand_a_i;
  logic [`EX_XLEN-1:0]       alu_operand_b_i;
  logic [`EX_XLEN-1:0]       alu_operand_c_i;
  logic                      mult_en_i;
  mult_op_e                  mult_operator_i;
  logic [`EX_XLEN-1:0]       mult_operand_a_i;
  logic [`EX_XLEN-1:0]       mult_operand_b_i;
  logic                      csr_access_i;
  logic [`EX_XLEN-1:0]       csr_rdata_i;
  logic                      lsu_en_i;
  logic                      branch_in_ex_i;
  logic                      regfile_alu_we_i;
  logic [`EX_REG_ADDR_W-1:0] regfile_alu_waddr_i;
  logic                      regfile_we_i;
  logic [`EX_REG_ADDR_W-1:0] regfile_waddr_i;
  logic [`EX_XLEN-1:0]       lsu_rdata_i;
  logic                      lsu_ready_ex_i;
  logic                      lsu_err_i;
  logic                      wb_ready_i;
  logic [`EX_XLEN-1:0]       regfile_alu_wdata_fw_o;
  logic [`EX_REG_ADDR_W-1:0] regfile_alu_waddr_fw_o;
  logic                      regfile_alu_we_fw_o;
  logic [`EX_XLEN-1:0]       regfile_wdata_wb_o;
  logic [`EX_REG_ADDR_W-1:0] regfile_waddr_wb_o;
  logic                      regfile_we_wb_o;
  logic                      branch_decision_o;
  logic [`EX_XLEN-1:0]       jump_target_o;
  logic                      mult_multicycle_o;
  logic                      ex_ready_o;
  logic                      ex_valid_o;

  logic [VEC_W-1:0]          golden [0:NUM_VEC-1];
  logic [31:0]               lcg_state;
  // Write port address only moves with a real write
  logic [`EX_REG_ADDR_W-1:0] exp_waddr;
  int                        error_count;
  int                        cycle_count = 0;

  always #2 clk = ~clk;

  ex_stage uut (.*);

  //////////////////////////////
  // Helpers
  //////////////////////////////

  function automatic logic [31:0] lcg_next(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
  endfunction

  // About one cycle in four stalls
  // No more than three stalls per operation
  task automatic draw_wb_ready(inout int stalls);
    lcg_state = lcg_next(lcg_state);
    if ((stalls < 3) && (lcg_state[17:16] == 2'b00)) begin
      wb_ready_i <= 1'b0;
      stalls++;
    end else begin
      wb_ready_i <= 1'b1;
    end
  endtask

  task automatic expect_word(input string what, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp) else begin
      error_count++;
      $display("CHECK FAILED at %0t ns: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic expect_bit(input string what, input logic got, input logic exp);
    assert (got === exp) else begin
      error_count++;
      $display("CHECK FAILED at %0t ns: %s is %b, expected %b", $time, what, got, exp);
    end
  endtask

  // Nothing valid and write-back ready
  task automatic drive_idle();
    alu_en_i       <= 1'b0;
    mult_en_i      <= 1'b0;
    csr_access_i   <= 1'b0;
    lsu_en_i       <= 1'b0;
    branch_in_ex_i <= 1'b0;
    wb_ready_i     <= 1'b1;
  endtask

  //////////////////////////////
  // One golden vector
  //////////////////////////////

  task automatic run_vector(input int idx);
    logic [VEC_W-1:0]          vec;
    logic [3:0]                kind;
    logic [3:0]                op;
    logic [`EX_XLEN-1:0]       opa;
    logic [`EX_XLEN-1:0]       opb;
    logic [`EX_XLEN-1:0]       opc;
    logic [`EX_XLEN-1:0]       exp_data;
    logic [`EX_XLEN-1:0]       rdata;
    logic                      we;
    logic                      err;
    logic                      exp_br;
    logic                      high_op;
    logic                      is_branch;
    logic                      valid_exp;
    logic [`EX_REG_ADDR_W-1:0] waddr;
    logic [`EX_REG_ADDR_W-1:0] fw_waddr;
    int                        addr_n;
    int                        cyc;
    int                        stalls;
    bit                        done;

    vec       = golden[idx];
    kind      = vec[147:144];
    op        = vec[143:140];
    opa       = vec[139:108];
    opb       = vec[107:76];
    opc       = vec[75:44];
    we        = vec[40];
    err       = vec[36];
    exp_data  = vec[35:4];
    exp_br    = vec[0];
    addr_n    = idx + 1;
    waddr     = addr_n[`EX_REG_ADDR_W-1:0];
    fw_waddr  = ~waddr;
    rdata     = (kind == KIND_LSU) ? opa : (opa ^ 32'h0f0f_0f0f);
    high_op   = (kind == KIND_MULT) && (op != 4'h0);
    is_branch = (kind == KIND_ALU) && (op >= 4'ha);
    cyc       = 0;
    stalls    = 0;
    done      = 1'b0;

    // Operands reach both units and only the enable picks the result
    alu_en_i            <= (kind == KIND_ALU);
    alu_operator_i      <= (kind == KIND_ALU) ? alu_op_e'(op) : ALU_ADD;
    alu_operand_a_i     <= opa;
    alu_operand_b_i     <= opb;
    alu_operand_c_i     <= opc;
    mult_en_i           <= (kind == KIND_MULT);
    mult_operator_i     <= mult_op_e'(op[1:0]);
    mult_operand_a_i    <= opa;
    mult_operand_b_i    <= opb;
    csr_access_i        <= (kind == KIND_CSR);
    csr_rdata_i         <= opa;
    lsu_en_i            <= (kind == KIND_LSU);
    branch_in_ex_i      <= is_branch;
    regfile_alu_we_i    <= idx[0];
    regfile_alu_waddr_i <= fw_waddr;
    regfile_we_i        <= we;
    regfile_waddr_i     <= waddr;
    lsu_err_i           <= err;
    lsu_rdata_i         <= rdata;
    draw_wb_ready(stalls);

    // Inputs hold until the stage reports valid
    while (!done) begin
      @(negedge clk);
      // Multiplier busy only in the first cycle of a high product
      valid_exp = wb_ready_i && !(high_op && (cyc == 0));
      if (cyc == 0) begin
        expect_bit("regfile_we_wb_o after idle", regfile_we_wb_o, 1'b0);
      end
      expect_bit("mult_multicycle_o", mult_multicycle_o, high_op && (cyc == 0));
      expect_bit("ex_valid_o", ex_valid_o, valid_exp);
      expect_bit("ex_ready_o", ex_ready_o, valid_exp || is_branch);
      if (ex_valid_o) begin
        expect_word("regfile_alu_wdata_fw_o", regfile_alu_wdata_fw_o, exp_data);
        expect_bit("branch_decision_o", branch_decision_o, exp_br);
        expect_word("jump_target_o", jump_target_o, opc);
        expect_bit("regfile_alu_we_fw_o", regfile_alu_we_fw_o, idx[0]);
        expect_word("regfile_alu_waddr_fw_o", 32'(regfile_alu_waddr_fw_o), 32'(fw_waddr));
        expect_word("regfile_wdata_wb_o", regfile_wdata_wb_o, rdata);
        done = 1'b1;
      end else begin
        @(posedge clk);
        cyc++;
        draw_wb_ready(stalls);
      end
    end

    // Idle cycle shows the captured write request and then flushes it
    @(posedge clk);
    drive_idle();
    if (we && !err) begin
      exp_waddr = waddr;
    end
    @(negedge clk);
    expect_bit("regfile_we_wb_o", regfile_we_wb_o, we && !err);
    expect_word("regfile_waddr_wb_o", 32'(regfile_waddr_wb_o), 32'(exp_waddr));
    @(posedge clk);
  endtask

  //////////////////////////////
  // Main sequence
  //////////////////////////////

  initial begin
    rst_n               = 1'b0;
    alu_en_i            = 1'b0;
    alu_operator_i      = ALU_ADD;
    alu_operand_a_i     = '0;
    alu_operand_b_i     = '0;
    alu_operand_c_i     = '0;
    mult_en_i           = 1'b0;
    mult_operator_i     = MUL_LO;
    mult_operand_a_i    = '0;
    mult_operand_b_i    = '0;
    csr_access_i        = 1'b0;
    csr_rdata_i         = '0;
    lsu_en_i            = 1'b0;
    branch_in_ex_i      = 1'b0;
    regfile_alu_we_i    = 1'b0;
    regfile_alu_waddr_i = '0;
    regfile_we_i        = 1'b0;
    regfile_waddr_i     = '0;
    lsu_rdata_i         = '0;
    lsu_ready_ex_i      = 1'b1;
    lsu_err_i           = 1'b0;
    wb_ready_i          = 1'b1;
    lcg_state           = 32'h24e7_daa0;
    exp_waddr           = '0;
    error_count         = 0;
    $readmemh("sim/ex_golden.mem", golden);

    repeat (RST_CYCLES) @(posedge clk);
    rst_n <= 1'b1;
    for (int v = 0; v < NUM_VEC; v++) begin
      run_vector(v);
    end
    @(negedge clk);
    expect_bit("regfile_we_wb_o after last idle", regfile_we_wb_o, 1'b0);

    $display("Checks done: %0d testbench errors, %0d assertion failures",
             error_count, uut.chk_u.fail_count);
    if ((error_count + uut.chk_u.fail_count) == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

  // Run limit
  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= MAX_CYCLES) begin
      $display("ERROR: timeout, the run did not finish within %0d cycles", MAX_CYCLES);
      $display("TEST FAIL");
      $finish;
    end
  end

endmodule

`default_nettype wire

// ==== sim/ex_stage_checker.sv ====
// Execute stage assertions
`timescale 1ns/1ns
`default_nettype none

module ex_stage_checker import ex_pkg::*; (
  input logic        clk,
  input logic        rst_n,
  input logic        ex_valid_i,
  input logic        ex_ready_i,
  input logic        wb_ready_i,
  input logic        branch_in_ex_i,
  input logic        mult_multicycle_i,
  input mult_state_e mult_state_i,
  input logic        regfile_we_wb_i
);

  int fail_count = 0;

  // Nothing leaves the stage unless write-back can take it
  valid_needs_wb: assert property (@(posedge clk) disable iff (!rst_n)
    ex_valid_i |-> wb_ready_i)
    else begin
      fail_count++;
      $error("ex_valid_o high while wb_ready_i is low");
    end

  // Busy multiplier holds the stage unless a branch frees it
  busy_not_ready: assert property (@(posedge clk) disable iff (!rst_n)
    mult_multicycle_i |-> !ex_valid_i && (!ex_ready_i || branch_in_ex_i))
    else begin
      fail_count++;
      $error("mult_multicycle_o high while the stage reports valid or ready");
    end

  // Write port idle right after reset
  wb_idle_after_reset: assert property (@(posedge clk)
    $rose(rst_n) |-> !regfile_we_wb_i)
    else begin
      fail_count++;
      $error("regfile_we_wb_o high in the first cycle after reset");
    end

  // High step lasts a single cycle
  high_one_cycle: assert property (@(posedge clk) disable iff (!rst_n)
    (mult_state_i == MS_HIGH) |=> (mult_state_i != MS_HIGH))
    else begin
      fail_count++;
      $error("multiplier stayed in MS_HIGH for two cycles");
    end

endmodule

bind ex_stage ex_stage_checker chk_u (
  .clk               (clk),
  .rst_n             (rst_n),
  .ex_valid_i        (ex_valid_o),
  .ex_ready_i        (ex_ready_o),
  .wb_ready_i        (wb_ready_i),
  .branch_in_ex_i    (branch_in_ex_i),
  .mult_multicycle_i (mult_multicycle_o),
  .mult_state_i      (mult_u.state),
  .regfile_we_wb_i   (regfile_we_wb_o)
);

`default_nettype wire

// ==== src/ex_stage.sv ====
// Execute stage top
`timescale 1ns/1ns
`default_nettype none

`include "ex_cfg.svh"

module ex_stage import ex_pkg::*; (
  input  logic                      clk,
  input  logic                      rst_n,

  // ALU operands from decode
  input  logic                      alu_en_i,
  input  alu_op_e                   alu_operator_i,
  input  logic [`EX_XLEN-1:0]       alu_operand_a_i,
  input  logic [`EX_XLEN-1:0]       alu_operand_b_i,
  input  logic [`EX_XLEN-1:0]       alu_operand_c_i,

  // Multiplier operands from decode
  input  logic                      mult_en_i,
  input  mult_op_e                  mult_operator_i,
  input  logic [`EX_XLEN-1:0]       mult_operand_a_i,
  input  logic [`EX_XLEN-1:0]       mult_operand_b_i,

  // CSR read data replaces the computed result
  input  logic                      csr_access_i,
  input  logic [`EX_XLEN-1:0]       csr_rdata_i,

  input  logic                      lsu_en_i,
  input  logic                      branch_in_ex_i,

  // Register file write controls
  input  logic                      regfile_alu_we_i,
  input  logic [`EX_REG_ADDR_W-1:0] regfile_alu_waddr_i,
  input  logic                      regfile_we_i,
  input  logic [`EX_REG_ADDR_W-1:0] regfile_waddr_i,

  // LSU and write-back side
  input  logic [`EX_XLEN-1:0]       lsu_rdata_i,
  input  logic                      lsu_ready_ex_i,
  input  logic                      lsu_err_i,
  input  logic                      wb_ready_i,

  // Forwarding port
  output logic [`EX_XLEN-1:0]       regfile_alu_wdata_fw_o,
  output logic [`EX_REG_ADDR_W-1:0] regfile_alu_waddr_fw_o,
  output logic                      regfile_alu_we_fw_o,

  // LSU write port
  output logic [`EX_XLEN-1:0]       regfile_wdata_wb_o,
  output logic [`EX_REG_ADDR_W-1:0] regfile_waddr_wb_o,
  output logic                      regfile_we_wb_o,

  output logic                      branch_decision_o,
  output logic [`EX_XLEN-1:0]       jump_target_o,

  output logic                      mult_multicycle_o,
  output logic                      ex_ready_o,
  output logic                      ex_valid_o
);

  logic [`EX_XLEN-1:0] alu_result;
  logic                alu_cmp_result;
  logic [`EX_XLEN-1:0] mult_result;
  logic                mult_ready;

  //////////////////////////////
  // Functional units
  //////////////////////////////

  ex_alu alu_u (
    .operator_i   (alu_operator_i),
    .operand_a_i  (alu_operand_a_i),
    .operand_b_i  (alu_operand_b_i),
    .result_o     (alu_result),
    .cmp_result_o (alu_cmp_result)
  );

  // Sequence advances on the stage ready, not the unit's own
  ex_mult mult_u (
    .clk          (clk),
    .rst_n        (rst_n),
    .enable_i     (mult_en_i),
    .operator_i   (mult_operator_i),
    .op_a_i       (mult_operand_a_i),
    .op_b_i       (mult_operand_b_i),
    .ex_ready_i   (ex_ready_o),
    .result_o     (mult_result),
    .ready_o      (mult_ready),
    .multicycle_o (mult_multicycle_o)
  );

  ex_wb_reg wb_reg_u (
    .clk                (clk),
    .rst_n              (rst_n),
    .ex_valid_i         (ex_valid_o),
    .wb_ready_i         (wb_ready_i),
    .regfile_we_i       (regfile_we_i),
    .regfile_waddr_i    (regfile_waddr_i),
    .lsu_err_i          (lsu_err_i),
    .lsu_rdata_i        (lsu_rdata_i),
    .regfile_we_wb_o    (regfile_we_wb_o),
    .regfile_waddr_wb_o (regfile_waddr_wb_o),
    .regfile_wdata_wb_o (regfile_wdata_wb_o)
  );

  //////////////////////////////
  // Forwarding port
  //////////////////////////////

  // CSR wins over multiplier, multiplier over ALU
  always_comb begin
    if (csr_access_i) begin
      regfile_alu_wdata_fw_o = csr_rdata_i;
    end else if (mult_en_i) begin
      regfile_alu_wdata_fw_o = mult_result;
    end else if (alu_en_i) begin
      regfile_alu_wdata_fw_o = alu_result;
    end else begin
      regfile_alu_wdata_fw_o = '0;
    end
  end

  assign regfile_alu_we_fw_o    = regfile_alu_we_i;
  assign regfile_alu_waddr_fw_o = regfile_alu_waddr_i;

  // Branch resolves here, target computed in decode
  assign branch_decision_o = alu_cmp_result;
  assign jump_target_o     = alu_operand_c_i;

  //////////////////////////////
  // Stall control
  //////////////////////////////

  // A branch finishes without write-back, so it frees the stage on its own
  assign ex_ready_o = (mult_ready & lsu_ready_ex_i & wb_ready_i) | branch_in_ex_i;

  // Valid flows forward only, independent of ready
  assign ex_valid_o = (alu_en_i | mult_en_i | csr_access_i | lsu_en_i) &
                      (mult_ready & lsu_ready_ex_i & wb_ready_i);

endmodule

`default_nettype wire

// ==== src/ex_wb_reg.sv ====
// EX/WB pipeline register
`timescale 1ns/1ns
`default_nettype none

`include "ex_cfg.svh"

module ex_wb_reg (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      ex_valid_i,
  input  logic                      wb_ready_i,
  input  logic                      regfile_we_i,
  input  logic [`EX_REG_ADDR_W-1:0] regfile_waddr_i,
  input  logic                      lsu_err_i,
  input  logic [`EX_XLEN-1:0]       lsu_rdata_i,
  output logic                      regfile_we_wb_o,
  output logic [`EX_REG_ADDR_W-1:0] regfile_waddr_wb_o,
  output logic [`EX_XLEN-1:0]       regfile_wdata_wb_o
);

  logic                      we_lsu;
  logic                      we_q;
  logic [`EX_REG_ADDR_W-1:0] waddr_q;

  // A faulting load must not reach the register file
  assign we_lsu = regfile_we_i & ~lsu_err_i;

  //////////////////////////////
  // Write request register
  //////////////////////////////

  // Valid already implies write-back ready
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      we_q    <= 1'b0;
      waddr_q <= '0;
    end else begin
      if (ex_valid_i) begin
        we_q <= we_lsu;
        // Address only moves with a real write
        if (we_lsu) begin
          waddr_q <= regfile_waddr_i;
        end
      end else if (wb_ready_i) begin
        // Write-back drained and nothing new, flush the entry
        we_q <= 1'b0;
      end
    end
  end

  assign regfile_we_wb_o    = we_q;
  assign regfile_waddr_wb_o = waddr_q;

  // Load data arrives from the LSU in the write-back cycle
  assign regfile_wdata_wb_o = lsu_rdata_i;

endmodule

`default_nettype wire

// ==== src/ex_mult.sv ====
// Integer multiplier
`timescale 1ns/1ns
`default_nettype none

`include "ex_cfg.svh"

module ex_mult import ex_pkg::*; (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                enable_i,
  input  mult_op_e            operator_i,
  input  logic [`EX_XLEN-1:0] op_a_i,
  input  logic [`EX_XLEN-1:0] op_b_i,
  input  logic                ex_ready_i,
  output logic [`EX_XLEN-1:0] result_o,
  output logic                ready_o,
  output logic                multicycle_o
);

  logic                  sign_a;
  logic                  sign_b;
  logic [2*`EX_XLEN-1:0] mul_a;
  logic [2*`EX_XLEN-1:0] mul_b;
  logic [2*`EX_XLEN-1:0] product;
  logic [2*`EX_XLEN-1:0] prod_q;
  mult_state_e           state_q;
  mult_state_e           state_d;
  mult_state_e           state;

  //////////////////////////////
  // Shared product
  //////////////////////////////

  // MULH treats both operands as signed, MULHSU only the first
  assign sign_a = (operator_i == MUL_H) || (operator_i == MUL_HSU);
  assign sign_b = (operator_i == MUL_H);

  assign mul_a = {{`EX_XLEN{sign_a & op_a_i[`EX_XLEN-1]}}, op_a_i};
  assign mul_b = {{`EX_XLEN{sign_b & op_b_i[`EX_XLEN-1]}}, op_b_i};

  // Low 64 bits of the extended product are exact for every opcode
  assign product = mul_a * mul_b;

  //////////////////////////////
  // High product sequence
  //////////////////////////////

  // A high opcode arriving in idle is already the register step
  always_comb begin
    state = state_q;
    if ((state_q == MS_IDLE) && enable_i && (operator_i != MUL_LO)) begin
      state = MS_HIGH;
    end
  end

  always_comb begin
    state_d = state;
    case (state)
      MS_IDLE: state_d = MS_IDLE;
      MS_HIGH: state_d = MS_DONE;
      // Hold the upper half until the stage moves on
      MS_DONE: begin
        if (ex_ready_i) begin
          state_d = MS_IDLE;
        end
      end
      default: state_d = MS_IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= MS_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Full product, captured once per high opcode
  always_ff @(posedge clk) begin
    if (state == MS_HIGH) begin
      prod_q <= product;
    end
  end

  assign ready_o      = (state != MS_HIGH);
  assign multicycle_o = (state == MS_HIGH);
  assign result_o     = (state == MS_DONE) ? prod_q[2*`EX_XLEN-1:`EX_XLEN]
                                           : product[`EX_XLEN-1:0];

endmodule

`default_nettype wire

// ==== src/ex_alu.sv ====
// Integer ALU
`timescale 1ns/1ns
`default_nettype none

`include "ex_cfg.svh"

module ex_alu import ex_pkg::*; (
  input  alu_op_e             operator_i,
  input  logic [`EX_XLEN-1:0] operand_a_i,
  input  logic [`EX_XLEN-1:0] operand_b_i,
  output logic [`EX_XLEN-1:0] result_o,
  output logic                cmp_result_o
);

  logic                   is_sub;
  logic                   is_signed;
  logic [`EX_XLEN:0]      add_a;
  logic [`EX_XLEN:0]      add_b;
  logic [`EX_XLEN:0]      add_sum;
  logic                   is_lt;
  logic                   is_eq;
  logic                   shift_left;
  logic                   shift_arith;
  logic [`EX_SHAMT_W-1:0] shamt;
  logic [`EX_XLEN-1:0]    shift_in;
  logic [`EX_XLEN-1:0]    fill_mask;
  logic [`EX_XLEN-1:0]    shift_right;
  logic [`EX_XLEN-1:0]    shift_result;

  //////////////////////////////
  // Adder / subtractor
  //////////////////////////////

  // Everything except add subtracts, compares included
  assign is_sub    = (operator_i != ALU_ADD);
  assign is_signed = (operator_i inside {ALU_SLT, ALU_LT, ALU_GE});

  // One extra bit, sign or zero extended, so the MSB of the sum is the less-than flag
  assign add_a   = {is_signed & operand_a_i[`EX_XLEN-1], operand_a_i};
  assign add_b   = is_sub ? ~{is_signed & operand_b_i[`EX_XLEN-1], operand_b_i}
                          :  {is_signed & operand_b_i[`EX_XLEN-1], operand_b_i};
  assign add_sum = add_a + add_b + {{`EX_XLEN{1'b0}}, is_sub};

  assign is_lt = add_sum[`EX_XLEN];
  assign is_eq = (operand_a_i == operand_b_i);

  //////////////////////////////
  // Barrel shifter
  //////////////////////////////

  assign shift_left  = (operator_i == ALU_SLL);
  assign shift_arith = (operator_i == ALU_SRA);
  assign shamt       = operand_b_i[`EX_SHAMT_W-1:0];

  // Left shifts reuse the right shifter on a bit-reversed operand
  always_comb begin
    for (int i = 0; i < `EX_XLEN; i++) begin
      shift_in[i] = shift_left ? operand_a_i[`EX_XLEN-1-i] : operand_a_i[i];
    end
  end

  // Vacated upper bits take the sign on arithmetic shifts
  assign fill_mask   = ~({`EX_XLEN{1'b1}} >> shamt) &
                       {`EX_XLEN{shift_arith & operand_a_i[`EX_XLEN-1]}};
  assign shift_right = (shift_in >> shamt) | fill_mask;

  // Undo the reversal
  always_comb begin
    for (int i = 0; i < `EX_XLEN; i++) begin
      shift_result[i] = shift_left ? shift_right[`EX_XLEN-1-i] : shift_right[i];
    end
  end

  //////////////////////////////
  // Compare and result select
  //////////////////////////////

  always_comb begin
    case (operator_i)
      ALU_SLT, ALU_SLTU, ALU_LT, ALU_LTU: cmp_result_o = is_lt;
      ALU_GE, ALU_GEU:                    cmp_result_o = ~is_lt;
      ALU_EQ:                             cmp_result_o = is_eq;
      ALU_NE:                             cmp_result_o = ~is_eq;
      default:                            cmp_result_o = 1'b0;
    endcase
  end

  // Branch compares leave the result at zero
  always_comb begin
    case (operator_i)
      ALU_ADD, ALU_SUB:          result_o = add_sum[`EX_XLEN-1:0];
      ALU_AND:                   result_o = operand_a_i & operand_b_i;
      ALU_OR:                    result_o = operand_a_i | operand_b_i;
      ALU_XOR:                   result_o = operand_a_i ^ operand_b_i;
      ALU_SLL, ALU_SRL, ALU_SRA: result_o = shift_result;
      ALU_SLT, ALU_SLTU:         result_o = {{(`EX_XLEN-1){1'b0}}, cmp_result_o};
      default:                   result_o = '0;
    endcase
  end

endmodule

`default_nettype wire

// ==== src/ex_pkg.sv ====
// Execute stage types
`default_nettype none

`include "ex_cfg.svh"

package ex_pkg;

  // ALU operations, the last six are branch compares
  typedef enum logic [`EX_ALU_OP_W-1:0] {
    ALU_ADD  = 4'h0, ALU_SUB  = 4'h1, ALU_AND = 4'h2, ALU_OR  = 4'h3,
    ALU_XOR  = 4'h4, ALU_SLL  = 4'h5, ALU_SRL = 4'h6, ALU_SRA = 4'h7,
    ALU_SLT  = 4'h8, ALU_SLTU = 4'h9, ALU_EQ  = 4'ha, ALU_NE  = 4'hb,
    ALU_LT   = 4'hc, ALU_GE   = 4'hd, ALU_LTU = 4'he, ALU_GEU = 4'hf
  } alu_op_e;

  // Multiplier operations
  typedef enum logic [`EX_MULT_OP_W-1:0] {
    MUL_LO  = 2'd0,
    MUL_H   = 2'd1,
    MUL_HSU = 2'd2,
    MUL_HU  = 2'd3
  } mult_op_e;

  // Steps of the high product sequence
  typedef enum logic [1:0] {
    MS_IDLE = 2'd0,
    MS_HIGH = 2'd1,
    MS_DONE = 2'd2
  } mult_state_e;

endpackage

`default_nettype wire

// ==== src/ex_cfg.svh ====
// Execute stage configuration
`ifndef EX_CFG_SVH
`define EX_CFG_SVH

// Datapath and operand width
`define EX_XLEN 32

// Register file address, covers integer and extended registers
`define EX_REG_ADDR_W 6

// Opcode field widths
`define EX_ALU_OP_W 4
`define EX_MULT_OP_W 2

// Shift amount, log2 of the datapath width
`define EX_SHAMT_W 5

`endif
